// ==== sources.f ====
logic/vector_pkg.sv
logic/vector_cla.sv
logic/vector_alu.sv
logic/vector_regfile.sv
logic/vector_decode.sv
logic/vector_csr.sv
logic/vector_unit.sv
testbench/vector_unit_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard logic/*.sv) testbench/vector_unit_tb.sv

obj_dir/Vvector_unit_tb: sources.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module vector_unit_tb -f sources.f

run: obj_dir/Vvector_unit_tb
	./obj_dir/Vvector_unit_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== testbench/vector_unit_tb.sv ====
`timescale 1ns/10ps

module vector_unit_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic        host_we;
    logic [4:0]  host_addr;
    logic [31:0] host_wdata;
    logic        csr_we;
    logic [1:0]  csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] host_rdata;
    logic [31:0] csr_rdata;
    logic        result_valid;
    logic [4:0]  result_rd;
    logic [31:0] result_data;

    int          seed;
    int          cyc;
    int          legal_count;
    logic        prev_legal;                      // Writeback pending on the coming edge
    logic        model_sew;
    logic        model_flag;
    logic [4:0]  last_rd;
    logic [31:0] ins;
    logic [31:0] rnd;
    logic [31:0] model_regs [vector_pkg::num_vregs];
    int          exp_due [$];                     // Cycle when each result must show
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    vector_unit vector_unit_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .host_rdata   (host_rdata),
        .csr_rdata    (csr_rdata),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_with_failure("an output did not match the model");
        end
    endtask

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= 5000)                          // Tests need about 2000 cycles
            stop_with_failure("timeout, the tests did not finish within 5000 cycles");
    end

    // Each legal instruction owes one result two edges after it is driven
    always @(negedge clk)
    begin
        if (rst_n && exp_due.size() > 0 && exp_due[0] == cyc)
        begin
            compare("result_valid", 32'd1, {31'd0, result_valid});
            compare("result_rd", {27'd0, exp_rd[0]}, {27'd0, result_rd});
            compare("result_data", exp_data[0], result_data);
            void'(exp_due.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end
        else if (rst_n && result_valid)
            stop_with_failure("result_valid was high with no result expected");
    end

    function automatic logic [31:0] alu_model(input logic [2:0] op, input logic sew,
                                              input vector_pkg::vec_word_t a,
                                              input vector_pkg::vec_word_t b);
        vector_pkg::vec_word_t r;
        logic                  sub;
        int                    acc;
        r   = a;                                  // VMV copies source 1
        sub = (op == vector_pkg::f3_vsub);
        acc = 0;
        if (op == vector_pkg::f3_vadd || sub)
        begin
            if (sew == vector_pkg::sew_16)
                for (int i = 0; i < 2; i++)
                    r.h[i] = sub ? a.h[i] - b.h[i] : a.h[i] + b.h[i];
            else
                for (int i = 0; i < 4; i++)
                    r.b[i] = sub ? a.b[i] - b.b[i] : a.b[i] + b.b[i];
        end
        else if (op == vector_pkg::f3_vdot)
        begin
            if (sew == vector_pkg::sew_16)
                for (int i = 0; i < 2; i++)
                    acc = acc + int'($signed(a.h[i])) * int'($signed(b.h[i]));
            else
                for (int i = 0; i < 4; i++)
                    acc = acc + int'($signed(a.b[i])) * int'($signed(b.b[i]));
            r = acc;
        end
        return r;
    endfunction

    function automatic logic is_legal(input logic [31:0] word);
        logic f3_ok;
        f3_ok = (word[14:12] == vector_pkg::f3_vadd) || (word[14:12] == vector_pkg::f3_vsub) ||
                (word[14:12] == vector_pkg::f3_vdot) || (word[14:12] == vector_pkg::f3_vmv);
        return (word[6:0] == vector_pkg::opc_vector) &&
               (word[31:25] == vector_pkg::f7_vector) && f3_ok;
    endfunction

    task automatic make_legal(output logic [31:0] word);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r = $random(seed);
        case (r[1:0])
            2'd0:    f3 = vector_pkg::f3_vadd;
            2'd1:    f3 = vector_pkg::f3_vsub;
            2'd2:    f3 = vector_pkg::f3_vdot;
            default: f3 = vector_pkg::f3_vmv;
        endcase
        rs1 = r[6:2];
        rs2 = r[11:7];
        if (r[17])                                // Half of them depend on the last result
        begin
            if (r[18])
                rs1 = last_rd;
            else
                rs2 = last_rd;
        end
        last_rd = r[16:12];
        word = {vector_pkg::f7_vector, rs2, rs1, f3, last_rd, vector_pkg::opc_vector};
    endtask

    task automatic make_illegal(output logic [31:0] word);
        logic [31:0] r;
        make_legal(word);
        r = $random(seed);
        case (r % 3)
            0:       word[6:0] = word[6:0] ^ (r[8:2] | 7'h01);
            1:       word[31:25] = r[15:9] | 7'h01;
            default: word[14:12] = (r[17:16] == 2'b10) ? 3'b011 : {1'b1, r[17:16]};
        endcase
    endtask

    // One clock of stimulus, mirrored into the model in edge order
    task automatic drive_cycle(input logic ins_v, input logic [31:0] word, input logic hwe,
                               input logic [4:0] haddr, input logic [31:0] hwdata,
                               input logic cwe, input logic [1:0] caddr,
                               input logic [31:0] cwdata);
        logic        legal;
        logic [31:0] res;
        @(posedge clk);
        #1;
        instr       = word;
        instr_valid = ins_v;
        host_we     = hwe;
        host_addr   = haddr;
        host_wdata  = hwdata;
        csr_we      = cwe;
        csr_addr    = caddr;
        csr_wdata   = cwdata;
        legal = ins_v && is_legal(word);
        res = alu_model(word[14:12], model_sew, model_regs[word[19:15]],
                        model_regs[word[24:20]]);
        if (hwe && !prev_legal)
            model_regs[haddr] = hwdata;           // Lost when a writeback shares the edge
        if (legal)
        begin
            exp_due.push_back(cyc + 2);
            exp_rd.push_back(word[11:7]);
            exp_data.push_back(res);
            model_regs[word[11:7]] = res;
            legal_count++;
        end
        if (ins_v && !legal)
            model_flag = 1'b1;
        if (cwe && caddr == vector_pkg::csr_sew)
            model_sew = cwdata[0];
        if (cwe && caddr == vector_pkg::csr_illegal)
            model_flag = 1'b0;
        prev_legal = legal;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b0, 2'd0, 32'd0);
    endtask

    task automatic check_reads(input logic [4:0] haddr, input logic [1:0] caddr,
                               input logic [31:0] exp_csr);
        drive_cycle(1'b0, 32'd0, 1'b0, haddr, 32'd0, 1'b0, caddr, 32'd0);
        @(negedge clk);
        compare("host_rdata", model_regs[haddr], host_rdata);
        compare("csr_rdata", exp_csr, csr_rdata);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < vector_pkg::num_vregs; i++)
            check_reads(5'(i), vector_pkg::csr_sew, {31'd0, model_sew});
    endtask

    initial
    begin
        seed        = 77;
        cyc         = 0;
        legal_count = 0;
        prev_legal  = 1'b0;
        model_sew   = vector_pkg::sew_8;
        model_flag  = 1'b0;
        last_rd     = 5'd0;
        foreach (model_regs[i])
            model_regs[i] = 32'd0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr       = 32'd0;
        instr_valid = 1'b0;
        host_we     = 1'b0;
        host_addr   = 5'd0;
        host_wdata  = 32'd0;
        csr_we      = 1'b0;
        csr_addr    = 2'd0;
        csr_wdata   = 32'd0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 9; i++)               // Everything clear after reset
            check_reads(5'($random(seed)), 2'(i % 3), 32'd0);
        for (int i = 0; i < vector_pkg::num_vregs; i++)
            drive_cycle(1'b0, 32'd0, 1'b1, 5'(i), $random(seed), 1'b0, 2'd0, 32'd0);

        for (int n = 0; n < 800; n++)
        begin
            make_legal(ins);
            drive_cycle(1'b1, ins, 1'b0, 5'd0, 32'd0, 1'b0, 2'd0, 32'd0);
        end
        idle(2);
        check_all_regs();

        drive_cycle(1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b1, vector_pkg::csr_sew, 32'd1);
        for (int n = 0; n < 800; n++)
        begin
            make_legal(ins);
            rnd = $random(seed);                  // Occasional width switch with the issue
            drive_cycle(1'b1, ins, 1'b0, 5'd0, 32'd0, rnd[3:0] == 4'd0,
                        vector_pkg::csr_sew, {31'd0, rnd[4]});
        end
        idle(2);
        check_all_regs();

        for (int n = 0; n < 40; n++)
        begin
            make_illegal(ins);
            drive_cycle(1'b1, ins, 1'b0, 5'd0, 32'd0, 1'b0, 2'd0, 32'd0);
        end
        idle(3);
        check_reads(5'd0, vector_pkg::csr_illegal, {31'd0, model_flag});
        check_all_regs();
        drive_cycle(1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b1, vector_pkg::csr_illegal, 32'd0);
        check_reads(5'd0, vector_pkg::csr_illegal, 32'd0);

        for (int n = 0; n < 40; n++)              // Host write collides with the writeback
        begin
            make_legal(ins);
            drive_cycle(1'b1, ins, 1'b0, 5'd0, 32'd0, 1'b0, 2'd0, 32'd0);
            drive_cycle(1'b0, 32'd0, 1'b1, last_rd, $random(seed), 1'b0, 2'd0, 32'd0);
            check_reads(last_rd, vector_pkg::csr_sew, {31'd0, model_sew});
        end

        idle(4);
        check_reads(5'd0, vector_pkg::csr_retired, legal_count);
        if (exp_due.size() != 0)
            stop_with_failure("some expected results never appeared");
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== logic/vector_unit.sv ====
`timescale 1ns/10ps

module vector_unit
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [31:0]                       instr,
    input  logic                              instr_valid,
    input  logic                              host_we,
    input  logic [vector_pkg::reg_addr_w-1:0] host_addr,
    input  logic [vector_pkg::vlen-1:0]       host_wdata,
    input  logic                              csr_we,
    input  logic [1:0]                        csr_addr,
    input  logic [vector_pkg::vlen-1:0]       csr_wdata,
    output logic [vector_pkg::vlen-1:0]       host_rdata,
    output logic [vector_pkg::vlen-1:0]       csr_rdata,
    output logic                              result_valid,
    output logic [vector_pkg::reg_addr_w-1:0] result_rd,
    output logic [vector_pkg::vlen-1:0]       result_data
);

    logic [vector_pkg::reg_addr_w-1:0] rs1_addr;
    logic [vector_pkg::reg_addr_w-1:0] rs2_addr;
    logic [vector_pkg::vlen-1:0]       rs1_data;
    logic [vector_pkg::vlen-1:0]       rs2_data;
    logic                              sew;
    logic                              iss_valid;
    logic [2:0]                        iss_op;
    logic                              iss_sew;
    logic [vector_pkg::reg_addr_w-1:0] iss_rd;
    vector_pkg::vec_word_t             iss_a;
    vector_pkg::vec_word_t             iss_b;
    logic                              iss_illegal;
    logic                              wb_en;
    logic [vector_pkg::reg_addr_w-1:0] wb_addr;
    logic [vector_pkg::vlen-1:0]       wb_data;

    vector_decode vector_decode_i
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .sew         (sew),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .iss_valid   (iss_valid),
        .iss_op      (iss_op),
        .iss_sew     (iss_sew),
        .iss_rd      (iss_rd),
        .iss_a       (iss_a),
        .iss_b       (iss_b),
        .iss_illegal (iss_illegal)
    );

    vector_regfile vector_regfile_i
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .host_rdata (host_rdata)
    );

    vector_alu vector_alu_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .iss_valid    (iss_valid),
        .iss_op       (iss_op),
        .iss_sew      (iss_sew),
        .iss_rd       (iss_rd),
        .iss_a        (iss_a),
        .iss_b        (iss_b),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    vector_csr vector_csr_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .iss_illegal  (iss_illegal),
        .result_valid (result_valid),
        .sew          (sew),
        .csr_rdata    (csr_rdata)
    );

endmodule

// ==== logic/vector_csr.sv ====
`timescale 1ns/10ps

module vector_csr
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        csr_we,
    input  logic [1:0]                  csr_addr,
    input  logic [vector_pkg::vlen-1:0] csr_wdata,
    input  logic                        iss_illegal,
    input  logic                        result_valid,
    output logic                        sew,
    output logic [vector_pkg::vlen-1:0] csr_rdata
);

    logic [vector_pkg::vlen-1:0] retired;
    logic                        illegal_flag;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sew          <= vector_pkg::sew_8;
            retired      <= '0;
            illegal_flag <= 1'b0;
        end
        else
        begin
            if (csr_we && (csr_addr == vector_pkg::csr_sew))
            begin
                sew <= csr_wdata[0];
            end
            if (result_valid)
            begin
                retired <= retired + 1'b1;
            end
            // A new illegal event beats a clear on the same edge
            if (iss_illegal)
            begin
                illegal_flag <= 1'b1;
            end
            else if (csr_we && (csr_addr == vector_pkg::csr_illegal))
            begin
                illegal_flag <= 1'b0;
            end
        end
    end

    always_comb
    begin
        case (csr_addr)
            vector_pkg::csr_sew:     csr_rdata = {{(vector_pkg::vlen-1){1'b0}}, sew};
            vector_pkg::csr_retired: csr_rdata = retired;
            vector_pkg::csr_illegal: csr_rdata = {{(vector_pkg::vlen-1){1'b0}}, illegal_flag};
            default:                 csr_rdata = '0;   // Unmapped address
        endcase
    end

endmodule

// ==== logic/vector_decode.sv ====
`timescale 1ns/10ps

module vector_decode
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [31:0]                       instr,
    input  logic                              instr_valid,
    input  logic [vector_pkg::vlen-1:0]       rs1_data,
    input  logic [vector_pkg::vlen-1:0]       rs2_data,
    input  logic                              sew,
    output logic [vector_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [vector_pkg::reg_addr_w-1:0] rs2_addr,
    output logic                              iss_valid,
    output logic [2:0]                        iss_op,
    output logic                              iss_sew,
    output logic [vector_pkg::reg_addr_w-1:0] iss_rd,
    output vector_pkg::vec_word_t             iss_a,
    output vector_pkg::vec_word_t             iss_b,
    output logic                              iss_illegal
);

    logic [6:0]                        opcode;
    logic [vector_pkg::reg_addr_w-1:0] rd;
    logic [2:0]                        funct3;
    logic [6:0]                        funct7;
    logic                              f3_ok;
    logic                              legal;

    // R-type field layout
    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign funct7   = instr[31:25];

    always_comb
    begin
        case (funct3)
            vector_pkg::f3_vadd,
            vector_pkg::f3_vsub,
            vector_pkg::f3_vdot,
            vector_pkg::f3_vmv: f3_ok = 1'b1;
            default:            f3_ok = 1'b0;     // Includes the dropped cross product
        endcase
    end

    assign legal = (opcode == vector_pkg::opc_vector) &&
                   (funct7 == vector_pkg::f7_vector) && f3_ok;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            iss_valid   <= 1'b0;
            iss_illegal <= 1'b0;
        end
        else
        begin
            iss_valid   <= instr_valid && legal;
            iss_illegal <= instr_valid && !legal;  // One-cycle pulse
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid && legal)
        begin
            iss_op  <= funct3;
            iss_sew <= sew;                       // Width locked at issue
            iss_rd  <= rd;
            iss_a   <= rs1_data;
            iss_b   <= rs2_data;
        end
    end

endmodule

// ==== logic/vector_regfile.sv ====
`timescale 1ns/10ps

module vector_regfile
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [vector_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [vector_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [vector_pkg::reg_addr_w-1:0] host_addr,
    input  logic                              host_we,
    input  logic [vector_pkg::vlen-1:0]       host_wdata,
    input  logic                              wb_en,
    input  logic [vector_pkg::reg_addr_w-1:0] wb_addr,
    input  logic [vector_pkg::vlen-1:0]       wb_data,
    output logic [vector_pkg::vlen-1:0]       rs1_data,
    output logic [vector_pkg::vlen-1:0]       rs2_data,
    output logic [vector_pkg::vlen-1:0]       host_rdata
);

    logic [vector_pkg::vlen-1:0] regs [vector_pkg::num_vregs];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < vector_pkg::num_vregs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_en)
        begin
            regs[wb_addr] <= wb_data;             // Writeback wins, host write dropped
        end
        else if (host_we)
        begin
            regs[host_addr] <= host_wdata;
        end
    end

    // Forward the result being written so a dependent issue sees it
    assign rs1_data   = (wb_en && (wb_addr == rs1_addr)) ? wb_data : regs[rs1_addr];
    assign rs2_data   = (wb_en && (wb_addr == rs2_addr)) ? wb_data : regs[rs2_addr];
    assign host_rdata = (wb_en && (wb_addr == host_addr)) ? wb_data : regs[host_addr];

endmodule

// ==== logic/vector_alu.sv ====
`timescale 1ns/10ps

module vector_alu
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              iss_valid,
    input  logic [2:0]                        iss_op,
    input  logic                              iss_sew,
    input  logic [vector_pkg::reg_addr_w-1:0] iss_rd,
    input  vector_pkg::vec_word_t             iss_a,
    input  vector_pkg::vec_word_t             iss_b,
    output logic                              wb_en,
    output logic [vector_pkg::reg_addr_w-1:0] wb_addr,
    output logic [vector_pkg::vlen-1:0]       wb_data,
    output logic                              result_valid,
    output logic [vector_pkg::reg_addr_w-1:0] result_rd,
    output logic [vector_pkg::vlen-1:0]       result_data
);

    logic                         is_sub;
    logic                         chain;
    logic [7:0]                   lane_b [4];
    logic [7:0]                   lane_sum [4];
    logic                         cout_0;
    logic                         cout_2;
    logic                         cin_1;
    logic                         cin_3;
    logic signed [vector_pkg::vlen-1:0] dot_sum;
    logic [vector_pkg::vlen-1:0]  alu_out;

    assign is_sub = (iss_op == vector_pkg::f3_vsub);
    assign chain  = (iss_sew == vector_pkg::sew_16);     // Pair byte adders into halves

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            lane_b[i] = is_sub ? ~iss_b.b[i] : iss_b.b[i];   // Two's complement via invert
        end
    end

    assign cin_1 = chain ? cout_0 : is_sub;
    assign cin_3 = chain ? cout_2 : is_sub;

    vector_cla #(.len(8)) cla_0
    (
        .a     (iss_a.b[0]),
        .b     (lane_b[0]),
        .c_in  (is_sub),
        .sum   (lane_sum[0]),
        .c_out (cout_0)
    );

    vector_cla #(.len(8)) cla_1
    (
        .a     (iss_a.b[1]),
        .b     (lane_b[1]),
        .c_in  (cin_1),
        .sum   (lane_sum[1]),
        .c_out ()
    );

    vector_cla #(.len(8)) cla_2
    (
        .a     (iss_a.b[2]),
        .b     (lane_b[2]),
        .c_in  (is_sub),
        .sum   (lane_sum[2]),
        .c_out (cout_2)
    );

    vector_cla #(.len(8)) cla_3
    (
        .a     (iss_a.b[3]),
        .b     (lane_b[3]),
        .c_in  (cin_3),
        .sum   (lane_sum[3]),
        .c_out ()
    );

    // Signed products widened to the full word before summing
    always_comb
    begin
        dot_sum = '0;
        if (chain)
        begin
            for (int i = 0; i < 2; i++)
            begin
                dot_sum = dot_sum + $signed(iss_a.h[i]) * $signed(iss_b.h[i]);
            end
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                dot_sum = dot_sum + $signed(iss_a.b[i]) * $signed(iss_b.b[i]);
            end
        end
    end

    always_comb
    begin
        case (iss_op)
            vector_pkg::f3_vadd,
            vector_pkg::f3_vsub: alu_out = {lane_sum[3], lane_sum[2], lane_sum[1], lane_sum[0]};
            vector_pkg::f3_vdot: alu_out = dot_sum;
            default:             alu_out = iss_a;   // VMV
        endcase
    end

    assign wb_en   = iss_valid;
    assign wb_addr = iss_rd;
    assign wb_data = alu_out;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (iss_valid)
        begin
            result_rd   <= iss_rd;
            result_data <= alu_out;
        end
    end

endmodule

// ==== logic/vector_cla.sv ====
`timescale 1ns/10ps

module vector_cla
#(
    parameter int len = 8
)
(
    input  logic [len-1:0] a,
    input  logic [len-1:0] b,
    input  logic           c_in,
    output logic [len-1:0] sum,
    output logic           c_out
);

    logic [len-1:0] gen;
    logic [len-1:0] prop;
    logic [len:0]   carry;

    assign gen  = a & b;                          // Carry generated in this bit
    assign prop = a ^ b;                          // Carry passed through this bit

    always_comb
    begin
        carry[0] = c_in;
        for (int i = 1; i <= len; i++)
        begin
            carry[i] = gen[i-1] | (prop[i-1] & carry[i-1]);
        end
    end

    // Full-adder sum bit from the lookahead carries
    assign sum   = prop ^ carry[len-1:0];
    assign c_out = carry[len];

endmodule

// ==== logic/vector_pkg.sv ====
package vector_pkg;

    localparam int vlen       = 32;               // Data word width
    localparam int num_vregs  = 32;               // Vector register count
    localparam int reg_addr_w = 5;                // Register address width

    localparam logic [6:0] opc_vector = 7'b0001011;   // Custom-0 opcode space

    localparam logic [2:0] f3_vadd = 3'b010;      // Lane-wise add
    localparam logic [2:0] f3_vsub = 3'b110;      // Lane-wise subtract
    localparam logic [2:0] f3_vdot = 3'b001;      // Signed dot product
    localparam logic [2:0] f3_vmv  = 3'b000;      // Copy source 1

    localparam logic [6:0] f7_vector = 7'b0000000;    // Only legal funct7

    localparam logic sew_8  = 1'b0;               // Four 8-bit lanes
    localparam logic sew_16 = 1'b1;               // Two 16-bit lanes

    localparam logic [1:0] csr_sew     = 2'd0;    // Element width, bit 0
    localparam logic [1:0] csr_retired = 2'd1;    // Retired count, read only
    localparam logic [1:0] csr_illegal = 2'd2;    // Sticky illegal flag

    // Same operand word, split by the element width in effect
    typedef union packed
    {
        logic [3:0][vlen/4-1:0] b;                // Byte lanes
        logic [1:0][vlen/2-1:0] h;                // Halfword lanes
    } vec_word_t;

endpackage
